// File: verif/rf_fwd_pipe_cases.txt
// issue op rd ra rb simm use_imm wr_en front_stall back_stall test, all hex, one line per clock
1 0 1 0 0 00000005 1 1 0 0 1
1 1 2 0 0 00000007 1 1 0 0 1
1 2 3 1 0 0000000c 1 1 0 0 1
1 3 4 2 1 00000000 0 1 0 0 1
1 4 5 2 0 0000ffff 1 1 0 0 1
1 5 6 1 0 00000023 1 1 0 0 1
1 6 7 2 0 0000001c 1 1 0 0 1
1 7 8 2 1 00000000 0 1 0 0 1
0 0 0 0 0 00000000 0 0 0 0 1
0 0 0 0 0 00000000 0 0 0 0 1
0 0 0 0 0 00000000 0 0 0 0 1
1 0 1 1 0 00000001 1 1 0 0 2
1 0 2 1 1 00000000 0 1 0 0 2
1 1 3 2 1 00000000 0 1 0 0 2
1 2 4 1 3 00000000 0 1 0 0 2
1 0 0 2 0 00000063 1 1 0 0 2
1 3 5 0 4 00000000 0 1 0 0 2
0 0 0 0 0 00000000 0 0 0 0 2
0 0 0 0 0 00000000 0 0 0 0 2
0 0 0 0 0 00000000 0 0 0 0 2
1 0 6 0 0 00000011 1 1 0 0 3
1 0 7 6 6 00000000 0 1 0 0 3
0 0 0 0 0 00000000 0 0 1 0 3
0 0 0 0 0 00000000 0 0 1 0 3
0 0 0 0 0 00000000 0 0 1 0 3
0 0 0 0 0 00000000 0 0 0 0 3
0 0 0 0 0 00000000 0 0 0 0 3
0 0 0 0 0 00000000 0 0 0 0 3
1 0 8 0 0 00000100 1 1 0 0 4
1 0 9 8 0 00000001 1 1 0 0 4
1 1 a 9 8 00000000 0 1 0 0 4
0 0 0 0 0 00000000 0 0 0 1 4
0 0 0 0 0 00000000 0 0 0 1 4
1 4 b a 9 00000000 0 1 0 0 4
0 0 0 0 0 00000000 0 0 0 0 4
0 0 0 0 0 00000000 0 0 0 0 4
0 0 0 0 0 00000000 0 0 0 0 4

// File: rf_fwd_pipe.f
hdl/rf_fwd_pkg.sv
hdl/pipe_ctrl.sv
hdl/reg_file.sv
hdl/operand_muxes.sv
hdl/alu_stage.sv
hdl/rf_fwd_pipe_top.sv
verif/rf_fwd_pipe_assert.sv
verif/rf_fwd_pipe_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the rf_fwd_pipe testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module rf_fwd_pipe_tb \
	-Mdir obj_dir \
	-f rf_fwd_pipe.f

# Pass only when the testbench printed its pass line
out="$(./obj_dir/Vrf_fwd_pipe_tb 2>&1)" || true
echo "$out"
if grep -qx "Test completed successfully" <<< "$out"; then
	exit 0
fi
exit 1

// File: verif/rf_fwd_pipe_tb.sv
/*
 * Testbench for rf_fwd_pipe_top, driven from verif/rf_fwd_pipe_cases.txt.
 * One case line per clock, applied 1 unit after the rising edge.
 * Results are checked in order against a 16-entry register model.
 * Every test must end with at least three idle lines so that the
 * pipeline is empty when the next test starts.
 */

module rf_fwd_pipe_tb;

	import rf_fwd_pkg::*;

	// One line of the cases file
	typedef struct packed {
		logic       issue;
		issue_t     op;
		logic       front_stall;
		logic       back_stall;
		logic [7:0] test;
	} case_t;

	// Expected WB result, in issue order
	typedef struct packed {
		reg_idx_t rd;
		data_t    data;
	} exp_t;

	logic     clk = 1'b0;
	logic     rst_n;
	logic     issue;
	issue_t   issue_op;
	logic     front_stall;
	logic     back_stall;
	logic     wb_valid;
	reg_idx_t wb_rd;
	data_t    wb_data;

	case_t cases [$];
	exp_t  exp_q [$];
	exp_t  head;
	data_t arch [16];
	logic  loaded = 1'b0;
	int    errors = 0;
	int    issued = 0;
	int    results = 0;
	int    test_results = 0;
	int    test_errors = 0;

	rf_fwd_pipe_top #(.NUM_REGS(16)) dut_i (
		.clk, .rst_n, .issue, .issue_op, .front_stall, .back_stall,
		.wb_valid, .wb_rd, .wb_data
	);

	always #4 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	// ALU rules, signed compare worked out from the sign bits
	function automatic data_t ref_alu(alu_op_t op, data_t a, data_t b);
		data_t r;
		case (op)
			ALU_ADD: r = a + b;
			ALU_SUB: r = a + ~b + 32'd1;
			ALU_AND: r = a & b;
			ALU_OR:  r = a | b;
			ALU_XOR: r = a ^ b;
			ALU_SLL: r = a << b[4:0];
			ALU_SRL: r = a >> b[4:0];
			default: begin
				if (a[31] != b[31])
					r = {31'd0, a[31]};
				else
					r = {31'd0, a < b};
			end
		endcase
		return r;
	endfunction

	// r0 and indices past the model read zero
	function automatic data_t arch_read(reg_idx_t idx);
		if (idx == '0 || idx >= 5'd16)
			return '0;
		return arch[idx[3:0]];
	endfunction

	task automatic note_error();
		errors++;
		test_errors++;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Cases file
	//////////////////////////////////////////////////////////////////////

	task automatic load_cases(output bit ok);
		int          fd;
		string       line;
		logic [31:0] fld [11];
		case_t       c;
		ok = 1'b0;
		fd = $fopen("verif/rf_fwd_pipe_cases.txt", "r");
		if (fd == 0)
			return;
		while ($fgets(line, fd) != 0) begin
			// Comment and blank lines
			if (line.len() < 2 || line[0] == "/")
				continue;
			if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
				fld[0], fld[1], fld[2], fld[3], fld[4], fld[5],
				fld[6], fld[7], fld[8], fld[9], fld[10]) != 11) begin
				$display("cases file line cannot be parsed: %s", line);
				note_error();
				continue;
			end
			c.issue       = fld[0][0];
			c.op.op       = alu_op_t'(fld[1][2:0]);
			c.op.rd       = fld[2][4:0];
			c.op.ra       = fld[3][4:0];
			c.op.rb       = fld[4][4:0];
			c.op.simm     = fld[5];
			c.op.use_imm  = fld[6][0];
			c.op.wr_en    = fld[7][0];
			c.front_stall = fld[8][0];
			c.back_stall  = fld[9][0];
			c.test        = fld[10][7:0];
			cases.push_back(c);
		end
		$fclose(fd);
		ok = (cases.size() != 0);
	endtask

	// Drive one line, and run an issued instruction on the model
	task automatic apply_case(case_t c);
		data_t a;
		data_t b;
		exp_t  e;
		issue       = c.issue;
		issue_op    = c.op;
		front_stall = c.front_stall;
		back_stall  = c.back_stall;
		if (c.issue) begin
			a      = arch_read(c.op.ra);
			b      = c.op.use_imm ? c.op.simm : arch_read(c.op.rb);
			e.rd   = c.op.rd;
			e.data = ref_alu(c.op.op, a, b);
			exp_q.push_back(e);
			issued++;
			if (c.op.wr_en && c.op.rd != '0 && c.op.rd < 5'd16)
				arch[c.op.rd[3:0]] = e.data;
		end
	endtask

	// All results of a test are due once its idle tail has passed
	task automatic report_test(logic [7:0] t);
		if (exp_q.size() != 0) begin
			$display("test %0d: %0d results never came out of WB", t, exp_q.size());
			note_error();
			exp_q.delete();
		end
		$display("test %0d done: %0d results, %0d errors", t, test_results, test_errors);
		test_results = 0;
		test_errors  = 0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Result checker, sampled mid-cycle
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		if (rst_n !== 1'b1) begin
			if (wb_valid !== 1'b0) begin
				$display("t=%0t: wb_valid not low during reset", $time);
				note_error();
			end
		end else if (wb_valid) begin
			results++;
			test_results++;
			if (exp_q.size() == 0) begin
				$display("t=%0t: wb_valid with no instruction outstanding", $time);
				note_error();
			end else begin
				head = exp_q.pop_front();
				if (wb_rd !== head.rd) begin
					$display("FAIL t=%0t wb_rd: got %0d expected %0d",
						$time, wb_rd, head.rd);
					note_error();
				end
				if (wb_data !== head.data) begin
					$display("FAIL t=%0t wb_data: got %h expected %h",
						$time, wb_data, head.data);
					note_error();
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin : main
		bit         ok;
		logic [7:0] prev_test;
		rst_n       = 1'b0;
		issue       = 1'b0;
		issue_op    = '0;
		front_stall = 1'b0;
		back_stall  = 1'b0;
		for (int i = 0; i < 16; i++)
			arch[i] = '0;
		load_cases(ok);
		if (!ok) begin
			$display("No cases read from verif/rf_fwd_pipe_cases.txt");
			$display("Test failed");
			$finish;
		end else begin
			loaded = 1'b1;
			repeat (8) @(posedge clk);
			#1 rst_n = 1'b1;
			prev_test = cases[0].test;
			foreach (cases[k]) begin
				@(posedge clk);
				#1;
				if (cases[k].test != prev_test) begin
					report_test(prev_test);
					prev_test = cases[k].test;
				end
				apply_case(cases[k]);
			end
			// Drain, then a few cycles to catch stray results
			while (exp_q.size() != 0)
				@(posedge clk);
			repeat (4) @(posedge clk);
			report_test(prev_test);
			if (results != issued) begin
				$display("%0d results seen for %0d instructions issued", results, issued);
				errors++;
			end
			$display("Summary: %0d issued, %0d results, %0d errors", issued, results, errors);
			if (errors == 0)
				$display("Test completed successfully");
			else
				$display("Test failed");
			$finish;
		end
	end

	// Reset, one cycle per line, and 20 cycles of slack
	initial begin : watchdog
		wait (loaded);
		repeat (cases.size() + 28) @(posedge clk);
		$display("Timeout after %0d cycles, pipeline did not drain", cases.size() + 28);
		$display("Test failed");
		$finish;
	end

endmodule

// File: verif/rf_fwd_pipe_assert.sv
/*
 * Concurrent checks bound into rf_fwd_pipe_top.
 * Covers the issue input rule, the WB bubble under back_stall
 * and wb_valid in reset.
 */

module rf_fwd_pipe_assert (
	input logic clk,
	input logic rst_n,
	input logic issue,
	input logic front_stall,
	input logic back_stall,
	input logic wb_valid
);

	// No issue into a frozen ID
	a_issue_rule: assert property (@(posedge clk) disable iff (!rst_n)
		issue |-> !(front_stall || back_stall))
		else $error("issue raised while a stall is high");

	// EX held, so WB gets a bubble
	a_back_bubble: assert property (@(posedge clk) disable iff (!rst_n)
		back_stall |=> !wb_valid)
		else $error("wb_valid high one cycle after back_stall");

	a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !wb_valid)
		else $error("wb_valid high during reset");

endmodule

bind rf_fwd_pipe_top rf_fwd_pipe_assert assert_i (.*);

// File: hdl/rf_fwd_pipe_top.sv
/*
 * ID / EX / WB slice with register-file operand forwarding.
 * issue must be low while front_stall or back_stall is high.
 * Without stalls a result shows on wb_valid three edges after issue.
 * NUM_REGS is the register-file depth, at most 32.
 */

module rf_fwd_pipe_top #(
	parameter int NUM_REGS = 16
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 issue,
	input  rf_fwd_pkg::issue_t   issue_op,
	input  logic                 front_stall,
	input  logic                 back_stall,
	output logic                 wb_valid,
	output rf_fwd_pkg::reg_idx_t wb_rd,
	output rf_fwd_pkg::data_t    wb_data
);

	import rf_fwd_pkg::*;

	logic      id_freeze;
	logic      ex_freeze;
	reg_idx_t  rd_idx_a;
	reg_idx_t  rd_idx_b;
	data_t     rf_dataa;
	data_t     rf_datab;
	opnd_sel_t sel_a;
	opnd_sel_t sel_b;
	data_t     simm;
	alu_op_t   ex_op;
	logic      ex_valid;
	logic      ex_wr_en;
	reg_idx_t  ex_rd;
	data_t     ex_forw;
	data_t     operand_a;
	data_t     operand_b;
	result_t   wb_res;

	// Control, ID register and hazard selection
	pipe_ctrl #(.NUM_REGS(NUM_REGS)) ctrl_i (
		.clk, .rst_n, .issue, .issue_op, .front_stall, .back_stall,
		.wb_res, .id_freeze, .ex_freeze, .rd_idx_a, .rd_idx_b,
		.sel_a, .sel_b, .simm, .ex_op, .ex_valid, .ex_wr_en, .ex_rd
	);

	// Written from WB
	reg_file #(.NUM_REGS(NUM_REGS)) rf_i (
		.clk, .rst_n, .rd_idx_a, .rd_idx_b, .rf_dataa, .rf_datab,
		.wr(wb_res)
	);

	operand_muxes opmux_i (
		.clk, .rst_n, .id_freeze, .ex_freeze, .rf_dataa, .rf_datab,
		.ex_forw, .wb_forw(wb_res.data), .simm, .sel_a, .sel_b,
		.operand_a, .operand_b
	);

	alu_stage alu_i (
		.clk, .rst_n, .ex_freeze, .operand_a, .operand_b, .ex_op,
		.ex_valid, .ex_wr_en, .ex_rd, .ex_forw, .wb_res
	);

	assign wb_valid = wb_res.valid;
	assign wb_rd    = wb_res.rd;
	assign wb_data  = wb_res.data;

endmodule

// File: hdl/alu_stage.sv
/*
 * EX stage ALU and the WB result register.
 * Shifts use the low 5 bits of operand B, SLT compares signed.
 * Under back_stall WB takes a bubble, the payload is kept.
 */

module alu_stage (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 ex_freeze,
	input  rf_fwd_pkg::data_t    operand_a,
	input  rf_fwd_pkg::data_t    operand_b,
	input  rf_fwd_pkg::alu_op_t  ex_op,
	input  logic                 ex_valid,
	input  logic                 ex_wr_en,
	input  rf_fwd_pkg::reg_idx_t ex_rd,
	output rf_fwd_pkg::data_t    ex_forw,
	output rf_fwd_pkg::result_t  wb_res
);

	import rf_fwd_pkg::*;

	logic     wb_valid_q;
	logic     wb_wr_en_q;
	reg_idx_t wb_rd_q;
	data_t    wb_data_q;

	//////////////////////////////////////////////////////////////////////
	// ALU
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (ex_op)
			ALU_ADD: ex_forw = operand_a + operand_b;
			ALU_SUB: ex_forw = operand_a - operand_b;
			ALU_AND: ex_forw = operand_a & operand_b;
			ALU_OR:  ex_forw = operand_a | operand_b;
			ALU_XOR: ex_forw = operand_a ^ operand_b;
			ALU_SLL: ex_forw = operand_a << operand_b[4:0];
			ALU_SRL: ex_forw = operand_a >> operand_b[4:0];
			ALU_SLT: ex_forw = data_t'($signed(operand_a) < $signed(operand_b));
			default: ex_forw = '0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// WB register
	//////////////////////////////////////////////////////////////////////

	// Control part, bubble while EX is frozen
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid_q <= 1'b0;
			wb_wr_en_q <= 1'b0;
			wb_rd_q    <= '0;
		end else if (ex_freeze) begin
			wb_valid_q <= 1'b0;
		end else begin
			wb_valid_q <= ex_valid;
			wb_wr_en_q <= ex_wr_en;
			wb_rd_q    <= ex_rd;
		end
	end

	// Result word
	always_ff @(posedge clk) begin
		if (!ex_freeze)
			wb_data_q <= ex_forw;
	end

	assign wb_res = '{valid: wb_valid_q, wr_en: wb_wr_en_q, rd: wb_rd_q, data: wb_data_q};

endmodule

// File: hdl/operand_muxes.sv
/*
 * Operand forwarding muxes and the EX operand registers.
 * While ID is frozen and EX runs, each operand is captured once
 * and then held, so a producer leaving WB is not lost.
 * The saved flag drops at the first edge with both freezes low.
 */

module operand_muxes (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  id_freeze,
	input  logic                  ex_freeze,
	input  rf_fwd_pkg::data_t     rf_dataa,
	input  rf_fwd_pkg::data_t     rf_datab,
	input  rf_fwd_pkg::data_t     ex_forw,
	input  rf_fwd_pkg::data_t     wb_forw,
	input  rf_fwd_pkg::data_t     simm,
	input  rf_fwd_pkg::opnd_sel_t sel_a,
	input  rf_fwd_pkg::opnd_sel_t sel_b,
	output rf_fwd_pkg::data_t     operand_a,
	output rf_fwd_pkg::data_t     operand_b
);

	import rf_fwd_pkg::*;

	// Index 0 is operand A, index 1 is operand B
	data_t muxed  [2];
	data_t opnd_q [2];
	logic  saved  [2];

	//////////////////////////////////////////////////////////////////////
	// Forwarding muxes
	//////////////////////////////////////////////////////////////////////

	// Operand A, no immediate source
	always_comb begin
		case (sel_a)
			SEL_EX_FORW: muxed[0] = ex_forw;
			SEL_WB_FORW: muxed[0] = wb_forw;
			default:     muxed[0] = rf_dataa;
		endcase
	end

	// Operand B
	always_comb begin
		case (sel_b)
			SEL_IMM:     muxed[1] = simm;
			SEL_EX_FORW: muxed[1] = ex_forw;
			SEL_WB_FORW: muxed[1] = wb_forw;
			default:     muxed[1] = rf_datab;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Operand registers
	//////////////////////////////////////////////////////////////////////

	// Load whenever EX runs and nothing is saved
	// The first load under an ID freeze marks the value as saved
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 2; i++) begin
				opnd_q[i] <= '0;
				saved[i]  <= 1'b0;
			end
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (!ex_freeze && !saved[i]) begin
					opnd_q[i] <= muxed[i];
					saved[i]  <= id_freeze;
				end else if (!ex_freeze && !id_freeze) begin
					// Release, the held value goes to EX as is
					saved[i] <= 1'b0;
				end
			end
		end
	end

	assign operand_a = opnd_q[0];
	assign operand_b = opnd_q[1];

endmodule

// File: hdl/reg_file.sv
/*
 * Register file, two combinational reads and one write.
 * Register 0 has no storage and reads zero.
 * Indices >= NUM_REGS read zero and are never written.
 * A write lands at the clock edge, same-cycle readers need forwarding.
 */

module reg_file #(
	parameter int NUM_REGS = 16
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  rf_fwd_pkg::reg_idx_t rd_idx_a,
	input  rf_fwd_pkg::reg_idx_t rd_idx_b,
	output rf_fwd_pkg::data_t    rf_dataa,
	output rf_fwd_pkg::data_t    rf_datab,
	input  rf_fwd_pkg::result_t  wr
);

	import rf_fwd_pkg::*;

	// r1 and up
	data_t regs [1:NUM_REGS-1];

	// Write port, dropped for r0 by the loop range
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wr.valid && wr.wr_en) begin
			for (int i = 1; i < NUM_REGS; i++) begin
				if (wr.rd == reg_idx_t'(i))
					regs[i] <= wr.data;
			end
		end
	end

	// Read ports, zero unless an existing register matches
	always_comb begin
		rf_dataa = '0;
		rf_datab = '0;
		for (int i = 1; i < NUM_REGS; i++) begin
			if (rd_idx_a == reg_idx_t'(i))
				rf_dataa = regs[i];
			if (rd_idx_b == reg_idx_t'(i))
				rf_datab = regs[i];
		end
	end

endmodule

// File: hdl/pipe_ctrl.sv
/*
 * Pipeline control: ID register, EX control bundle, freezes and
 * operand source selection.
 * issue must stay low while either stall is high; it is not
 * checked here and an issue during a freeze is dropped.
 * Source indices >= NUM_REGS read as zero, writes to them are dropped.
 */

module pipe_ctrl #(
	parameter int NUM_REGS = 16
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  issue,
	input  rf_fwd_pkg::issue_t    issue_op,
	input  logic                  front_stall,
	input  logic                  back_stall,
	input  rf_fwd_pkg::result_t   wb_res,
	output logic                  id_freeze,
	output logic                  ex_freeze,
	output rf_fwd_pkg::reg_idx_t  rd_idx_a,
	output rf_fwd_pkg::reg_idx_t  rd_idx_b,
	output rf_fwd_pkg::opnd_sel_t sel_a,
	output rf_fwd_pkg::opnd_sel_t sel_b,
	output rf_fwd_pkg::data_t     simm,
	output rf_fwd_pkg::alu_op_t   ex_op,
	output logic                  ex_valid,
	output logic                  ex_wr_en,
	output rf_fwd_pkg::reg_idx_t  ex_rd
);

	import rf_fwd_pkg::*;

	logic     id_valid;
	issue_t   id_ins;
	reg_idx_t src_a;
	reg_idx_t src_b;
	logic     id_wr_ok;

	// Hazard check for one source index
	// EX has priority, it holds the younger result
	function automatic opnd_sel_t fwd_sel(
		input reg_idx_t src,
		input logic     exv,
		input logic     exw,
		input reg_idx_t exrd,
		input result_t  wb
	);
		opnd_sel_t sel;
		sel = SEL_RF;
		if (src != '0) begin
			if (exv && exw && exrd == src)
				sel = SEL_EX_FORW;
			else if (wb.valid && wb.wr_en && wb.rd == src)
				sel = SEL_WB_FORW;
		end
		return sel;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Freezes
	//////////////////////////////////////////////////////////////////////

	// front_stall holds ID only, back_stall holds ID and EX
	assign id_freeze = front_stall | back_stall;
	assign ex_freeze = back_stall;

	//////////////////////////////////////////////////////////////////////
	// ID stage
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_valid <= 1'b0;
			id_ins   <= '0;
		end else if (!id_freeze) begin
			id_valid <= issue;
			id_ins   <= issue_op;
		end
	end

	// Out of range sources collapse to r0, which reads zero
	assign src_a = (int'(id_ins.ra) < NUM_REGS) ? id_ins.ra : '0;
	assign src_b = (int'(id_ins.rb) < NUM_REGS) ? id_ins.rb : '0;

	// Out of range destination never writes and never forwards
	assign id_wr_ok = id_ins.wr_en && (int'(id_ins.rd) < NUM_REGS);

	assign rd_idx_a = src_a;
	assign rd_idx_b = src_b;
	assign simm     = id_ins.simm;

	// Operand sources from live EX and WB contents
	assign sel_a = fwd_sel(src_a, ex_valid, ex_wr_en, ex_rd, wb_res);
	assign sel_b = id_ins.use_imm ? SEL_IMM
	                              : fwd_sel(src_b, ex_valid, ex_wr_en, ex_rd, wb_res);

	//////////////////////////////////////////////////////////////////////
	// EX control bundle
	//////////////////////////////////////////////////////////////////////

	// Advances with EX; a held ID feeds a bubble
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_valid <= 1'b0;
			ex_wr_en <= 1'b0;
			ex_rd    <= '0;
			ex_op    <= ALU_ADD;
		end else if (!ex_freeze) begin
			ex_valid <= id_valid && !id_freeze;
			ex_wr_en <= id_wr_ok;
			ex_rd    <= id_ins.rd;
			ex_op    <= id_ins.op;
		end
	end

endmodule

// File: hdl/rf_fwd_pkg.sv
/*
 * Shared types for the forwarding pipeline slice.
 * Data path is fixed at 32 bits with 5-bit register indices,
 * so the register file can be at most 32 deep.
 * opnd_sel_t keeps the encodings of the original operand mux.
 */

package rf_fwd_pkg;

	localparam int DATA_W = 32;
	localparam int IDX_W  = 5;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [IDX_W-1:0]  reg_idx_t;

	// ALU operations, all single cycle
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLL = 3'd5,
		ALU_SRL = 3'd6,
		ALU_SLT = 3'd7
	} alu_op_t;

	// Operand source select
	typedef enum logic [1:0] {
		SEL_RF      = 2'd0,
		SEL_IMM     = 2'd1,
		SEL_EX_FORW = 2'd2,
		SEL_WB_FORW = 2'd3
	} opnd_sel_t;

	// Pre-decoded instruction as it enters ID
	typedef struct packed {
		alu_op_t  op;
		reg_idx_t rd;
		reg_idx_t ra;
		reg_idx_t rb;
		data_t    simm;    // already sign-extended
		logic     use_imm; // operand B from simm
		logic     wr_en;   // result goes to rd
	} issue_t;

	// WB stage content, also the register-file write port
	typedef struct packed {
		logic     valid;
		logic     wr_en;
		reg_idx_t rd;
		data_t    data;
	} result_t;

endpackage
